// ==== src/cache_pkg.sv ====
package cache_pkg;

    // geometry
    localparam int WAYS     = 2;
    localparam int SETS     = 256;
    localparam int BANKS    = 4;        // words per line
    localparam int INDEX_W  = 8;
    localparam int TAG_W    = 20;
    localparam int OFFSET_W = 4;

    localparam logic [7:0] LFSR_SEED = 8'h01;

    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [OFFSET_W-1:0]       offset_t;
    typedef logic [$clog2(BANKS)-1:0]  bank_t;
    typedef logic [31:0]               word_t;
    typedef logic [3:0]                wstrb_t;

    // tag array entry
    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    // raw request from the core, op 1 = store
    typedef struct packed {
        logic    op;
        tag_t    tag;
        index_t  index;
        offset_t offset;
        wstrb_t  wstrb;
        word_t   wdata;
    } cpu_req_t;

    typedef struct packed {
        logic   op;
        tag_t   tag;
        index_t index;
        bank_t  bank;
        word_t  wdata;
        word_t  wmask;     // strobes expanded to bits
    } req_buf_t;

    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        tag_t                   tag;
        word_t [BANKS-1:0]      line;
    } victim_t;

endpackage

// ==== src/mem_bus_pkg.sv ====
package mem_bus_pkg;

    localparam int BEATS_PER_LINE = 4;

    typedef logic [31:0] bus_addr_t;

    // one full line, word 0 in the low bits
    typedef logic [BEATS_PER_LINE-1:0][31:0] line_t;

    // refill beat from memory
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } beat_t;

    // write-back of a whole dirty line
    typedef struct packed {
        bus_addr_t addr;   // line aligned
        line_t     data;
    } wr_line_t;

endpackage

// ==== src/cache_ram.sv ====
`timescale 1ns/1ps

module cache_ram
    import cache_pkg::*;
#(
    parameter type entry_t = word_t,
    parameter int  DEPTH   = SETS
) (
    input  logic   clk,
    input  logic   resetn,
    input  logic   we,
    input  index_t addr,
    input  entry_t wdata,
    output entry_t rdata
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];   // old data on a same-cycle write
        end
    end

endmodule

// ==== src/req_decode.sv ====
`timescale 1ns/1ps

module req_decode
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     valid,
    input  cpu_req_t req,
    input  logic     addr_ok,
    output req_buf_t req_buf,
    output index_t   ram_index
);

    req_buf_t dec;

    always_comb begin
        dec.op    = req.op;
        dec.tag   = req.tag;
        dec.index = req.index;
        dec.bank  = req.offset[3:2];   // word within the line
        dec.wdata = req.wdata;
        for (int i = 0; i < 4; i++) begin
            dec.wmask[8*i +: 8] = {8{req.wstrb[i]}};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_buf <= '0;
        end else if (valid && addr_ok) begin
            req_buf <= dec;
        end
    end

    // arrays read the new index while idle so tags are ready in lookup
    assign ram_index = addr_ok ? req.index : req_buf.index;

endmodule

// ==== src/cache_ways.sv ====
`timescale 1ns/1ps

module cache_ways
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  index_t   ram_index,
    input  req_buf_t req_buf,
    input  logic     lookup,
    input  logic     victim_way,
    input  logic     refill_we,
    input  bank_t    refill_bank,
    input  logic     refill_last,
    input  logic     crit_beat,
    input  beat_t    ret,
    output logic     hit,
    output logic     hit_way,
    output word_t    hit_word,
    output victim_t  victim
);

    tagv_t            tagv_q [WAYS];
    word_t            data_q [WAYS][BANKS];
    logic [SETS-1:0]  dirty_q [WAYS];
    logic [WAYS-1:0]  way_hit;
    word_t            store_word;
    word_t            refill_word;
    word_t            bank_wdata;
    tagv_t            tagv_wdata;

    assign hit      = |way_hit;
    assign hit_way  = way_hit[1];
    assign hit_word = data_q[hit_way][req_buf.bank];

    // store data merged over the old word, or over the critical beat
    assign store_word  = (hit_word & ~req_buf.wmask) | (req_buf.wdata & req_buf.wmask);
    assign refill_word = (crit_beat && req_buf.op)
                       ? ((ret.data & ~req_buf.wmask) | (req_buf.wdata & req_buf.wmask))
                       : ret.data;
    assign bank_wdata  = lookup ? store_word : refill_word;

    assign tagv_wdata.tag   = req_buf.tag;
    assign tagv_wdata.valid = 1'b1;

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        assign way_hit[w] = tagv_q[w].valid && (tagv_q[w].tag == req_buf.tag);

        cache_ram #(.entry_t(tagv_t), .DEPTH(SETS)) u_tagv (
            .clk   (clk),
            .resetn(resetn),
            .we    (refill_last && (victim_way == 1'(w))),   // tag lands with the last beat
            .addr  (ram_index),
            .wdata (tagv_wdata),
            .rdata (tagv_q[w])
        );

        for (genvar b = 0; b < BANKS; b++) begin : g_bank
            logic bank_we;

            assign bank_we = (lookup && req_buf.op && way_hit[w] && (req_buf.bank == bank_t'(b)))
                          || (refill_we && (victim_way == 1'(w)) && (refill_bank == bank_t'(b)));

            cache_ram #(.entry_t(word_t), .DEPTH(SETS)) u_data (
                .clk   (clk),
                .resetn(resetn),
                .we    (bank_we),
                .addr  (ram_index),
                .wdata (bank_wdata),
                .rdata (data_q[w][b])
            );
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < WAYS; w++) begin
                dirty_q[w] <= '0;
            end
        end else if (lookup && req_buf.op && hit) begin
            dirty_q[hit_way][req_buf.index] <= 1'b1;
        end else if (refill_last) begin
            dirty_q[victim_way][req_buf.index] <= req_buf.op;   // store miss leaves it dirty
        end
    end

    always_comb begin
        victim.valid = tagv_q[victim_way].valid;
        victim.dirty = dirty_q[victim_way][req_buf.index];
        victim.tag   = tagv_q[victim_way].tag;
        for (int b = 0; b < BANKS; b++) begin
            victim.line[b] = data_q[victim_way][b];
        end
    end

endmodule

// ==== src/miss_ctrl.sv ====
`timescale 1ns/1ps

module miss_ctrl
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      valid,
    input  req_buf_t  req_buf,
    input  logic      hit,
    input  victim_t   victim,
    input  logic      rd_rdy,
    input  logic      ret_valid,
    input  beat_t     ret,
    input  logic      wr_rdy,
    output logic      addr_ok,
    output logic      lookup,
    output logic      victim_way,
    output logic      refill_we,
    output bank_t     refill_bank,
    output logic      refill_last,
    output logic      crit_beat,
    output logic      rd_req,
    output bus_addr_t rd_addr,
    output logic      wr_req,
    output wr_line_t  wr_line
);

    // one-hot main FSM
    typedef enum logic [4:0] {
        S_IDLE    = 5'b00001,
        S_LOOKUP  = 5'b00010,
        S_MISS    = 5'b00100,
        S_REPLACE = 5'b01000,
        S_REFILL  = 5'b10000
    } state_t;

    state_t state_q;
    state_t state_d;
    logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt_q;
    logic       first_replace_q;
    logic [7:0] lfsr_q;
    logic       lfsr_fb;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (valid) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                state_d = hit ? S_IDLE : S_MISS;
            end
            S_MISS: begin
                if (wr_rdy) begin
                    state_d = S_REPLACE;   // write-back slot is free
                end
            end
            S_REPLACE: begin
                if (rd_rdy) begin
                    state_d = S_REFILL;
                end
            end
            S_REFILL: begin
                if (ret_valid && ret.last) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q         <= S_IDLE;
            first_replace_q <= 1'b0;
        end else begin
            state_q         <= state_d;
            first_replace_q <= (state_q == S_MISS) && wr_rdy;
        end
    end

    // beat counter, wraps after last
    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt_q <= '0;
        end else if (refill_last) begin
            beat_cnt_q <= '0;
        end else if (refill_we) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
        end
    end

    assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr_q <= LFSR_SEED;
        end else if (refill_last) begin
            lfsr_q <= {lfsr_q[6:0], lfsr_fb};
        end
    end

    assign victim_way = lfsr_q[0];

    assign addr_ok     = (state_q == S_IDLE);
    assign lookup      = (state_q == S_LOOKUP);
    assign refill_we   = (state_q == S_REFILL) && ret_valid;
    assign refill_bank = beat_cnt_q;
    assign refill_last = refill_we && ret.last;
    assign crit_beat   = refill_we && (beat_cnt_q == req_buf.bank);

    assign rd_req  = (state_q == S_REPLACE);
    assign rd_addr = {req_buf.tag, req_buf.index, 4'b0};

    // victim is still intact here, refill writes come later
    assign wr_req       = first_replace_q && victim.valid && victim.dirty;
    assign wr_line.addr = {victim.tag, req_buf.index, 4'b0};
    assign wr_line.data = victim.line;

endmodule

// ==== src/load_result.sv ====
`timescale 1ns/1ps

module load_result
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic     lookup,
    input  logic     hit,
    input  req_buf_t req_buf,
    input  logic     crit_beat,
    input  beat_t    ret,
    input  word_t    hit_word,
    output logic     data_ok,
    output word_t    rdata
);

    // stores finish in lookup even on a miss
    assign data_ok = (lookup && (hit || req_buf.op))
                  || (crit_beat && !req_buf.op);   // load miss, requested word

    assign rdata = lookup ? hit_word : ret.data;

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    // core side
    input  logic      valid,
    input  cpu_req_t  req,
    output logic      addr_ok,
    output logic      data_ok,
    output word_t     rdata,
    // memory read
    output logic      rd_req,
    output bus_addr_t rd_addr,
    input  logic      rd_rdy,
    input  logic      ret_valid,
    input  beat_t     ret,
    // memory write
    output logic      wr_req,
    output wr_line_t  wr_line,
    input  logic      wr_rdy
);

    req_buf_t req_buf;
    index_t   ram_index;
    logic     hit;
    logic     hit_way;
    word_t    hit_word;
    victim_t  victim;
    logic     lookup;
    logic     victim_way;
    logic     refill_we;
    bank_t    refill_bank;
    logic     refill_last;
    logic     crit_beat;

    req_decode u_decode (
        .clk      (clk),
        .resetn   (resetn),
        .valid    (valid),
        .req      (req),
        .addr_ok  (addr_ok),
        .req_buf  (req_buf),
        .ram_index(ram_index)
    );

    cache_ways u_ways (
        .clk        (clk),
        .resetn     (resetn),
        .ram_index  (ram_index),
        .req_buf    (req_buf),
        .lookup     (lookup),
        .victim_way (victim_way),
        .refill_we  (refill_we),
        .refill_bank(refill_bank),
        .refill_last(refill_last),
        .crit_beat  (crit_beat),
        .ret        (ret),
        .hit        (hit),
        .hit_way    (hit_way),
        .hit_word   (hit_word),
        .victim     (victim)
    );

    miss_ctrl u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .valid      (valid),
        .req_buf    (req_buf),
        .hit        (hit),
        .victim     (victim),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret        (ret),
        .wr_rdy     (wr_rdy),
        .addr_ok    (addr_ok),
        .lookup     (lookup),
        .victim_way (victim_way),
        .refill_we  (refill_we),
        .refill_bank(refill_bank),
        .refill_last(refill_last),
        .crit_beat  (crit_beat),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .wr_req     (wr_req),
        .wr_line    (wr_line)
    );

    load_result u_result (
        .lookup   (lookup),
        .hit      (hit),
        .req_buf  (req_buf),
        .crit_beat(crit_beat),
        .ret      (ret),
        .hit_word (hit_word),
        .data_ok  (data_ok),
        .rdata    (rdata)
    );

endmodule

// ==== bench/dcache_asserts.sv ====
`timescale 1ns/1ps

module dcache_asserts (
    input logic clk,
    input logic resetn,
    input logic valid,
    input logic addr_ok,
    input logic lookup,
    input logic crit_beat,
    input logic rd_req,
    input logic rd_rdy,
    input logic wr_req
);

    int   fail_count = 0;
    logic in_flight;   // a request was accepted and has not returned to idle

    always_ff @(posedge clk) begin
        if (!resetn) begin
            in_flight <= 1'b0;
        end else if (valid && addr_ok) begin
            in_flight <= 1'b1;
        end else if (addr_ok) begin
            in_flight <= 1'b0;
        end
    end

    a_wr_pulse: assert property (@(posedge clk) disable iff (!resetn) wr_req |=> !wr_req)
        else begin $error("wr_req high for two cycles"); fail_count++; end

    a_rd_hold: assert property (@(posedge clk) disable iff (!resetn)
        (rd_req && !rd_rdy) |=> rd_req)
        else begin $error("rd_req dropped before rd_rdy"); fail_count++; end

    a_idle_no_read: assert property (@(posedge clk) disable iff (!resetn) !(addr_ok && rd_req))
        else begin $error("rd_req while idle"); fail_count++; end

    // lookup and crit_beat are the only sources of data_ok
    a_data_ok_req: assert property (@(posedge clk) disable iff (!resetn)
        (lookup || crit_beat) |-> in_flight)
        else begin $error("data_ok source without an accepted request"); fail_count++; end

endmodule

bind miss_ctrl dcache_asserts asserts0 (
    .clk      (clk),
    .resetn   (resetn),
    .valid    (valid),
    .addr_ok  (addr_ok),
    .lookup   (lookup),
    .crit_beat(crit_beat),
    .rd_req   (rd_req),
    .rd_rdy   (rd_rdy),
    .wr_req   (wr_req)
);

// ==== bench/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache
    import cache_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int NUM_ROWS    = 15;

    typedef struct {
        string     name;
        logic      op;         // 1 = store
        bus_addr_t addr;
        wstrb_t    wstrb;
        word_t     wdata;
        word_t     exp_data;   // word value after this row
        logic      fast;       // data_ok due in the lookup cycle
    } row_t;

    logic      clk;
    logic      resetn;
    logic      valid;
    cpu_req_t  req;
    logic      addr_ok;
    logic      data_ok;
    word_t     rdata;
    logic      rd_req;
    bus_addr_t rd_addr;
    logic      rd_rdy;
    logic      ret_valid;
    beat_t     ret;
    logic      wr_req;
    wr_line_t  wr_line;
    logic      wr_rdy;

    row_t      rows [NUM_ROWS];
    word_t     mem_words [bus_addr_t];   // sparse backing store
    bus_addr_t first_wb_addr = '0;
    int        wb_count = 0;
    int        seed = 32'h87d4_146d;

    dcache_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t mem_read(input bus_addr_t addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return addr ^ 32'h5a5a_0000;   // never written
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic set_row(input int idx, input string name, input logic op,
                           input bus_addr_t addr, input wstrb_t wstrb, input word_t wdata,
                           input word_t exp_data, input logic fast);
        rows[idx] = '{name, op, addr, wstrb, wdata, exp_data, fast};
    endtask

    // one request, from valid to data_ok
    task automatic run_row(input int i);
        int cycles;
        @(posedge clk);
        #DRIVE_DELAY;
        valid      = 1'b1;
        req.op     = rows[i].op;
        req.tag    = rows[i].addr[31:12];
        req.index  = rows[i].addr[11:4];
        req.offset = rows[i].addr[3:0];
        req.wstrb  = rows[i].wstrb;
        req.wdata  = rows[i].wdata;
        do @(negedge clk); while (!addr_ok);   // accepted at the next edge
        @(posedge clk);
        #DRIVE_DELAY;
        valid  = 1'b0;
        cycles = 1;
        @(negedge clk);
        while (!data_ok) begin
            cycles++;
            @(negedge clk);
        end
        if (rows[i].fast) begin
            check_value({rows[i].name, " latency"}, 32'd1, cycles);
        end
        if (!rows[i].op) begin
            check_value(rows[i].name, rows[i].exp_data, rdata);
        end
    endtask

    // memory side: random ready levels, beats with random gaps
    initial begin : memory_model
        logic      burst_on;
        bus_addr_t burst_addr;
        int        beat_idx;
        rd_rdy     = 1'b0;
        wr_rdy     = 1'b0;
        ret_valid  = 1'b0;
        ret        = '0;
        burst_on   = 1'b0;
        burst_addr = '0;
        beat_idx   = 0;
        forever begin
            @(negedge clk);
            if (resetn && wr_req) begin
                for (int b = 0; b < BEATS_PER_LINE; b++) begin
                    mem_words[wr_line.addr + 4 * b] = wr_line.data[b];
                end
                if (wb_count == 0) begin
                    first_wb_addr = wr_line.addr;
                end
                wb_count++;
            end
            if (ret_valid) begin
                beat_idx++;
                if (beat_idx == BEATS_PER_LINE) begin
                    burst_on = 1'b0;
                end
            end
            if (rd_req && rd_rdy) begin   // burst starts at the next edge
                burst_on   = 1'b1;
                burst_addr = rd_addr;
                beat_idx   = 0;
            end
            @(posedge clk);
            #DRIVE_DELAY;
            rd_rdy    = ($random(seed) & 3) != 0;
            wr_rdy    = ($random(seed) & 1) != 0;
            ret_valid = burst_on && (($random(seed) & 1) != 0);
            ret.data  = mem_read(burst_addr + 4 * beat_idx);
            ret.last  = (beat_idx == BEATS_PER_LINE - 1);
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (NUM_ROWS * 200 + 10));
        $display("timeout: the requests did not complete within %0d cycles", NUM_ROWS * 200);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    always @(dut0.u_ctrl.asserts0.fail_count) begin
        if (dut0.u_ctrl.asserts0.fail_count != 0) begin
            $display("a protocol assertion on the miss controller failed");
            $display("TEST FAIL");
            $fatal(1, "assertion failure");
        end
    end

    initial begin : stimulus
        resetn = 1'b0;
        valid  = 1'b0;
        req    = '0;
        // lines A, B and C share index 8'h20
        set_row(0,  "load miss after reset",  0, 32'h0000_1004, 4'h0, 32'h0, 32'h5a5a_1004, 0);
        set_row(1,  "load hit same line",     0, 32'h0000_1008, 4'h0, 32'h0, 32'h5a5a_1008, 1);
        set_row(2,  "store hit partial",      1, 32'h0000_1008, 4'h5, 32'haabb_ccdd,
                32'h5abb_10dd, 1);
        set_row(3,  "load after store hit",   0, 32'h0000_1008, 4'h0, 32'h0, 32'h5abb_10dd, 1);
        set_row(4,  "store miss",             1, 32'h0000_2010, 4'hc, 32'h1122_3344,
                32'h1122_2010, 1);
        set_row(5,  "load after store miss",  0, 32'h0000_2010, 4'h0, 32'h0, 32'h1122_2010, 1);
        set_row(6,  "store line A",           1, 32'h0001_0200, 4'hf, 32'hcafe_0001,
                32'hcafe_0001, 1);
        set_row(7,  "store line B",           1, 32'h0002_0204, 4'hf, 32'hcafe_0002,
                32'hcafe_0002, 1);
        set_row(8,  "store line C",           1, 32'h0003_0208, 4'h3, 32'hcafe_0003,
                32'h5a59_0003, 1);
        set_row(9,  "reload line A",          0, 32'h0001_0200, 4'h0, 32'h0, 32'hcafe_0001, 0);
        set_row(10, "reload line B",          0, 32'h0002_0204, 4'h0, 32'h0, 32'hcafe_0002, 0);
        set_row(11, "reload line C",          0, 32'h0003_0208, 4'h0, 32'h0, 32'h5a59_0003, 0);
        set_row(12, "load untouched word",    0, 32'h0000_100c, 4'h0, 32'h0, 32'h5a5a_100c, 1);
        set_row(13, "load new tag in set 0",  0, 32'h0000_3008, 4'h0, 32'h0, 32'h5a5a_3008, 0);
        set_row(14, "load stored word again", 0, 32'h0000_1008, 4'h0, 32'h0, 32'h5abb_10dd, 1);
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        resetn = 1'b1;
        @(negedge clk);
        check_value("addr_ok after reset", 32'd1, addr_ok);
        check_value("data_ok after reset", 32'd0, data_ok);
        check_value("rd_req after reset", 32'd0, rd_req);
        check_value("wr_req after reset", 32'd0, wr_req);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        check_value("first write-back address", 32'h0001_0200, first_wb_addr);   // line A evicted
        if (dut0.u_ctrl.asserts0.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "assertion failures at the end of the run");
        end
    end

endmodule

// ==== compile.f ====
src/cache_pkg.sv
src/mem_bus_pkg.sv
src/cache_ram.sv
src/req_decode.sv
src/cache_ways.sv
src/miss_ctrl.sv
src/load_result.sv
src/dcache_top.sv
bench/dcache_asserts.sv
bench/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - src/cache_pkg.sv
      - src/mem_bus_pkg.sv
      - src/cache_ram.sv
      - src/req_decode.sv
      - src/cache_ways.sv
      - src/miss_ctrl.sv
      - src/load_result.sv
      - src/dcache_top.sv
  - target: test
    files:
      - bench/dcache_asserts.sv
      - bench/tb_dcache.sv
